// ==== verilog/fm_pkg.sv ====
package fm_pkg;

    localparam int REG_W      = 8;
    localparam int NUM_CH     = 6;
    localparam int BUSY_TICKS = 32;

    // Part-0 global register numbers
    localparam logic [REG_W-1:0] REG_TEST     = 8'h21;
    localparam logic [REG_W-1:0] REG_LFO      = 8'h22;
    localparam logic [REG_W-1:0] REG_TIMA_HI  = 8'h24;
    localparam logic [REG_W-1:0] REG_TIMA_LO  = 8'h25;
    localparam logic [REG_W-1:0] REG_TIMB     = 8'h26;
    localparam logic [REG_W-1:0] REG_TIMER    = 8'h27;
    localparam logic [REG_W-1:0] REG_KEYON    = 8'h28;
    localparam logic [REG_W-1:0] REG_PCM      = 8'h2A;
    localparam logic [REG_W-1:0] REG_PCM_EN   = 8'h2B;
    localparam logic [REG_W-1:0] REG_DAC_TEST = 8'h2C;
    localparam logic [REG_W-1:0] REG_CLK_N6   = 8'h2D;
    localparam logic [REG_W-1:0] REG_CLK_N3   = 8'h2E;
    localparam logic [REG_W-1:0] REG_CLK_N2   = 8'h2F;

    // Register groups (upper nibble) for channel and operator registers
    localparam logic [3:0] GRP_OP_FIRST = 4'h3;   // dt1/mul
    localparam logic [3:0] GRP_OP_LAST  = 4'h9;   // ssg-eg
    localparam logic [3:0] GRP_FNUM     = 4'hA;
    localparam logic [3:0] GRP_ALG_PMS  = 4'hB;

    typedef struct packed {
        logic [3:0] group;
        logic [1:0] op;       // 0=S1, 1=S3, 2=S2, 3=S4
        logic [1:0] ch;
    } reg_fields_t;

    typedef union packed {
        logic [REG_W-1:0] num;
        reg_fields_t      f;
    } reg_addr_u;

    typedef struct packed {
        logic             valid;
        logic             part;
        reg_addr_u        sel;
        logic [REG_W-1:0] data;
    } bus_wr_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_flag_a;
        logic       clr_flag_b;
    } timer_ctrl_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } lfo_t;

    typedef struct packed {
        logic [8:0] sample;
        logic       en;
        logic       wr;
    } pcm_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
        logic fast_timers;
    } test_t;

    typedef struct packed {
        logic [2:0] chreg;    // fnum-low, alg, pms
        logic [6:0] opreg;    // dt1, tl, ks_ar, amen_dr, sr, sl_rr, ssgeg
        logic       keyon;
        logic [2:0] ch;
        logic [1:0] op;
    } upd_t;

    typedef logic [1:0] div_sel_t;

endpackage

// ==== verilog/fm_bus_latch.sv ====
`timescale 1ns/1ps

// Two-step host bus where an address phase picks the register and part
// and a data phase carries the byte and fires the strobe
module fm_bus_latch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     write,
    input  logic [1:0]               addr,
    input  logic [fm_pkg::REG_W-1:0] din,
    output fm_pkg::bus_wr_t          wr
);

    logic addr_wr;
    logic data_wr;

    assign addr_wr = write && !addr[0];
    assign data_wr = write && addr[0];

    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr.data <= din;             // Payload copy
        end

        if (rst) begin
            wr.valid   <= 1'b0;
            wr.part    <= 1'b0;
            wr.sel.num <= '0;
        end else begin
            wr.valid <= data_wr;        // One cycle per data write
            if (addr_wr) begin
                wr.sel.num <= din;
                wr.part    <= addr[1];
            end
        end
    end

endmodule

// ==== verilog/fm_clk_div.sv ====
`timescale 1ns/1ps

module fm_clk_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  fm_pkg::div_sel_t div_sel,
    output logic             clk_en
);

    fm_pkg::div_sel_t cur_sel;   // Setting in use until next wrap
    logic [2:0]       cnt;
    logic [2:0]       last;

    // Last count value for /6, /3 and /2
    always_comb begin
        case (cur_sel)
            2'b11, 2'b10: last = 3'd5;
            2'b01:        last = 3'd2;
            default:      last = 3'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            cur_sel <= 2'b11;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= cen && (cnt == last);
            if (cen) begin
                if (cnt == last) begin
                    cnt     <= '0;
                    cur_sel <= div_sel;   // New divider only at wrap
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/fm_busy.sv ====
`timescale 1ns/1ps

module fm_busy (
    input  logic            clk,
    input  logic            rst,
    input  fm_pkg::bus_wr_t wr,
    input  logic            clk_en,
    output logic            busy
);

    localparam int CNT_W = $clog2(fm_pkg::BUSY_TICKS);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(fm_pkg::BUSY_TICKS - 1);

    logic [CNT_W-1:0] tick_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
        end else if (wr.valid) begin
            busy     <= 1'b1;           // Restart on every data write
            tick_cnt <= '0;
        end else if (clk_en && busy) begin
            if (tick_cnt == LAST_TICK) begin
                busy <= 1'b0;
            end
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/fm_global_regs.sv ====
`timescale 1ns/1ps

// Part-0 global registers of the FM core
module fm_global_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                clk_en,
    input  fm_pkg::bus_wr_t     wr,
    output fm_pkg::timer_ctrl_t timer,
    output fm_pkg::lfo_t        lfo,
    output fm_pkg::pcm_t        pcm,
    output fm_pkg::test_t       test,
    output fm_pkg::div_sel_t    div_sel
);

    logic [fm_pkg::REG_W-1:0] d;
    logic                     glb_wr;

    assign d      = wr.data;
    assign glb_wr = wr.valid && !wr.part;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer   <= '0;
            lfo     <= '0;
            pcm     <= '0;
            test    <= '0;
            div_sel <= 2'b11;           // Power-up is divide by 6
        end else if (glb_wr) begin
            pcm.wr <= (wr.sel.num == fm_pkg::REG_PCM);
            case (wr.sel.num)
                fm_pkg::REG_TEST: begin
                    test.eg_stop     <= d[5];
                    test.pg_stop     <= d[3];
                    test.fast_timers <= d[2];
                end
                fm_pkg::REG_LFO: begin
                    lfo.en   <= d[3];
                    lfo.freq <= d[2:0];
                end
                fm_pkg::REG_TIMA_HI: timer.value_a[9:2] <= d;
                fm_pkg::REG_TIMA_LO: timer.value_a[1:0] <= d[1:0];
                fm_pkg::REG_TIMB:    timer.value_b      <= d;
                fm_pkg::REG_TIMER: begin
                    timer.clr_flag_b <= d[5];
                    timer.clr_flag_a <= d[4];
                    timer.irq_en_b   <= d[3];
                    timer.irq_en_a   <= d[2];
                    timer.load_b     <= d[1];
                    timer.load_a     <= d[0];
                end
                // DAC sample in offset binary with a forced low bit
                fm_pkg::REG_PCM:      pcm.sample    <= {~d[7], d[6:0], 1'b1};
                fm_pkg::REG_DAC_TEST: pcm.sample[0] <= d[3];
                fm_pkg::REG_PCM_EN:   pcm.en        <= d[7];
                // Prescaler commands
                fm_pkg::REG_CLK_N6: div_sel[1] <= 1'b1;
                fm_pkg::REG_CLK_N3: div_sel[0] <= 1'b1;
                fm_pkg::REG_CLK_N2: div_sel    <= 2'b00;
                default: ;
            endcase
        end else if (clk_en && !wr.valid) begin
            // Single-tick bits
            timer.clr_flag_a <= 1'b0;
            timer.clr_flag_b <= 1'b0;
            pcm.wr           <= 1'b0;
        end
    end

endmodule

// ==== verilog/fm_update_decode.sv ====
`timescale 1ns/1ps

// Turns a channel or operator register write into one-hot strobes
module fm_update_decode #(
    parameter int NUM_CH = fm_pkg::NUM_CH
) (
    input  logic            clk,
    input  logic            rst,
    input  fm_pkg::bus_wr_t wr,
    output fm_pkg::upd_t    upd
);

    fm_pkg::reg_fields_t fld;
    logic [2:0]          ch_num;      // 0..5 across both parts
    logic                ch_ok;
    logic [2:0]          chreg_nxt;
    logic [6:0]          opreg_nxt;

    assign fld    = wr.sel.f;
    assign ch_num = {1'b0, fld.ch} + (wr.part ? 3'd3 : 3'd0);
    assign ch_ok  = (fld.ch != 2'd3) && (int'(ch_num) < NUM_CH);

    always_comb begin
        chreg_nxt = '0;
        opreg_nxt = '0;
        if (ch_ok) begin
            if (fld.group >= fm_pkg::GRP_OP_FIRST && fld.group <= fm_pkg::GRP_OP_LAST) begin
                opreg_nxt = 7'd1 << (fld.group - fm_pkg::GRP_OP_FIRST);
            end else if (fld.group == fm_pkg::GRP_FNUM && fld.op == 2'd0) begin
                chreg_nxt = 3'b001;                 // A0-A2
            end else if (fld.group == fm_pkg::GRP_ALG_PMS && fld.op == 2'd0) begin
                chreg_nxt = 3'b010;                 // B0-B2
            end else if (fld.group == fm_pkg::GRP_ALG_PMS && fld.op == 2'd1) begin
                chreg_nxt = 3'b100;                 // B4-B6
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            upd <= '0;
        end else if (wr.valid) begin
            upd.chreg <= chreg_nxt;
            upd.opreg <= opreg_nxt;
            upd.keyon <= !wr.part && (wr.sel.num == fm_pkg::REG_KEYON);
            upd.ch    <= {wr.part, fld.ch};
            upd.op    <= fld.op;
        end
    end

endmodule

// ==== verilog/fm_mmr.sv ====
`timescale 1ns/1ps

module fm_mmr #(
    parameter int NUM_CH = fm_pkg::NUM_CH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    write,
    input  logic [fm_pkg::REG_W-1:0] din,
    input  logic [1:0]              addr,
    output logic                    clk_en,
    output logic                    busy,
    output fm_pkg::timer_ctrl_t     timer,
    output fm_pkg::lfo_t            lfo,
    output fm_pkg::pcm_t            pcm,
    output fm_pkg::test_t           test,
    output fm_pkg::upd_t            upd
);

    fm_pkg::bus_wr_t  bus_wr;
    fm_pkg::div_sel_t div_sel;

    fm_bus_latch u_bus_latch (
        .clk   (clk),
        .rst   (rst),
        .write (write),
        .addr  (addr),
        .din   (din),
        .wr    (bus_wr)
    );

    fm_clk_div u_clk_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_busy u_busy (
        .clk    (clk),
        .rst    (rst),
        .wr     (bus_wr),
        .clk_en (clk_en),
        .busy   (busy)
    );

    fm_global_regs u_global_regs (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .wr      (bus_wr),
        .timer   (timer),
        .lfo     (lfo),
        .pcm     (pcm),
        .test    (test),
        .div_sel (div_sel)
    );

    fm_update_decode #(
        .NUM_CH (NUM_CH)
    ) u_update_decode (
        .clk (clk),
        .rst (rst),
        .wr  (bus_wr),
        .upd (upd)
    );

endmodule

// ==== dv/fm_checker.sv ====
`timescale 1ns/1ps

// Reference model of the register front end that checks the DUT outputs
module fm_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     write,
    input  logic [1:0]               addr,
    input  logic [fm_pkg::REG_W-1:0] din,
    input  logic [10:0]              exp_strb,   // {chreg, opreg, keyon} from the table
    input  logic                     clk_en,
    input  logic                     busy,
    input  fm_pkg::timer_ctrl_t      timer,
    input  fm_pkg::lfo_t             lfo,
    input  fm_pkg::pcm_t             pcm,
    input  fm_pkg::test_t            test,
    input  fm_pkg::upd_t             upd,
    output int                       errors,
    output int                       checks
);

    fm_pkg::timer_ctrl_t m_timer;
    fm_pkg::lfo_t        m_lfo;
    fm_pkg::pcm_t        m_pcm;
    fm_pkg::test_t       m_test;
    logic [1:0]          m_div;
    logic [7:0]          m_sel;      // Register picked by the last address write
    logic                m_part;
    logic [2:0]          m_ch;
    logic [1:0]          m_op;
    logic                rst_d;
    logic                busy_d;
    logic                clr_arm;    // Waiting for the clk_en that clears single-tick bits
    logic                clr_chk;
    int                  cyc;
    int                  last_en;
    int                  en_skip;
    int                  cmp_wait;
    int                  ticks;

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // Cycles between clk_en pulses for a prescaler setting
    function automatic int div_len(input logic [1:0] sel);
        if (sel[1]) begin
            return 6;
        end
        return sel[0] ? 3 : 2;
    endfunction

    task automatic model_write();
        m_ch = {m_part, m_sel[1:0]};
        m_op = m_sel[3:2];
        if (!m_part) begin
            m_pcm.wr = (m_sel == fm_pkg::REG_PCM);
            case (m_sel)
                fm_pkg::REG_TEST: begin
                    m_test.eg_stop     = din[5];
                    m_test.pg_stop     = din[3];
                    m_test.fast_timers = din[2];
                end
                fm_pkg::REG_LFO:      m_lfo = {din[3], din[2:0]};
                fm_pkg::REG_TIMA_HI:  m_timer.value_a[9:2] = din;
                fm_pkg::REG_TIMA_LO:  m_timer.value_a[1:0] = din[1:0];
                fm_pkg::REG_TIMB:     m_timer.value_b = din;
                fm_pkg::REG_TIMER: begin
                    {m_timer.clr_flag_b, m_timer.clr_flag_a} = din[5:4];
                    {m_timer.irq_en_b, m_timer.irq_en_a}     = din[3:2];
                    {m_timer.load_b, m_timer.load_a}         = din[1:0];
                end
                fm_pkg::REG_PCM:      m_pcm.sample = {~din[7], din[6:0], 1'b1};
                fm_pkg::REG_DAC_TEST: m_pcm.sample[0] = din[3];
                fm_pkg::REG_PCM_EN:   m_pcm.en = din[7];
                fm_pkg::REG_CLK_N6:   m_div[1] = 1'b1;
                fm_pkg::REG_CLK_N3:   m_div[0] = 1'b1;
                fm_pkg::REG_CLK_N2:   m_div = 2'b00;
                default: ;
            endcase
        end
    endtask

    task automatic compare_all();
        check_hex("busy", 32'(busy), 32'd1);
        check_hex("timer", 32'(timer), 32'(m_timer));
        check_hex("lfo", 32'(lfo), 32'(m_lfo));
        check_hex("pcm", 32'(pcm), 32'(m_pcm));
        check_hex("test", 32'(test), 32'(m_test));
        check_hex("upd strobes", 32'({upd.chreg, upd.opreg, upd.keyon}), 32'(exp_strb));
        check_hex("upd.ch", 32'(upd.ch), 32'(m_ch));
        check_hex("upd.op", 32'(upd.op), 32'(m_op));
        m_timer.clr_flag_a = 1'b0;
        m_timer.clr_flag_b = 1'b0;
        m_pcm.wr           = 1'b0;
        clr_arm            = 1'b1;
    endtask

    always @(posedge clk) begin
        cyc++;
        if (rst) begin
            m_timer  = '0;
            m_lfo    = '0;
            m_pcm    = '0;
            m_test   = '0;
            m_div    = 2'b11;
            m_sel    = '0;
            m_part   = 1'b0;
            m_ch     = '0;
            m_op     = '0;
            busy_d   = 1'b0;
            clr_arm  = 1'b0;
            clr_chk  = 1'b0;
            en_skip  = 1;
            cmp_wait = 0;
            ticks    = 0;
        end else begin
            if (rst_d) begin
                // First cycle out of reset
                check_hex("busy,clk_en", 32'({busy, clk_en}), 32'd0);
                check_hex("timer", 32'(timer), 32'd0);
                check_hex("lfo,pcm,test", 32'({lfo, pcm, test}), 32'd0);
                check_hex("upd", 32'(upd), 32'd0);
            end
            if (clr_chk) begin
                check_hex("single-tick bits", 32'({timer.clr_flag_a, timer.clr_flag_b, pcm.wr}), 0);
                clr_chk = 1'b0;
            end
            if (cmp_wait > 0) begin
                cmp_wait--;
                if (cmp_wait == 0) begin
                    compare_all();
                end
            end
            if (clr_arm && clk_en) begin
                clr_chk = 1'b1;
                clr_arm = 1'b0;
            end
            if (clk_en) begin
                if (en_skip > 0) begin
                    en_skip--;                  // Interval may straddle a divider change
                end else begin
                    check_hex("clk_en spacing", cyc - last_en, div_len(m_div));
                end
                last_en = cyc;
            end
            if (busy && clk_en) begin
                ticks++;
            end
            if (busy_d && !busy) begin
                checks++;
                if (ticks < fm_pkg::BUSY_TICKS - 1 || ticks > fm_pkg::BUSY_TICKS + 1) begin
                    errors++;
                    $display("ERROR busy ticks: got 0x%0h expected 0x%0h", ticks,
                             fm_pkg::BUSY_TICKS);
                end
                ticks = 0;
            end
            busy_d = busy;
            if (write && !addr[0]) begin
                m_sel  = din;
                m_part = addr[1];
            end
            if (write && addr[0]) begin
                model_write();
                cmp_wait = 2;                   // Outputs settle two edges later
                en_skip  = 2;
                ticks    = 0;
            end
        end
        rst_d = rst;
    end

endmodule

// ==== dv/tb_fm_mmr.sv ====
`timescale 1ns/1ps

module tb_fm_mmr;

    typedef struct packed {
        logic [3:0]  id;
        logic        part;
        logic [7:0]  num;
        logic        rnd;     // Data byte from $urandom
        logic [7:0]  data;
        logic [10:0] strb;    // Expected {chreg, opreg, keyon}
    } row_t;

    logic                clk;
    logic                rst;
    logic                cen;
    logic                write;
    logic [7:0]          din;
    logic [1:0]          addr;
    logic [10:0]         exp_strb;
    logic                clk_en;
    logic                busy;
    fm_pkg::timer_ctrl_t timer;
    fm_pkg::lfo_t        lfo;
    fm_pkg::pcm_t        pcm;
    fm_pkg::test_t       test;
    fm_pkg::upd_t        upd;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  cycle_limit;
    row_t                rows[$];

    fm_mmr #(.NUM_CH(fm_pkg::NUM_CH)) UUT (
        .clk(clk), .rst(rst), .cen(cen), .write(write), .din(din), .addr(addr),
        .clk_en(clk_en), .busy(busy), .timer(timer), .lfo(lfo), .pcm(pcm),
        .test(test), .upd(upd)
    );

    fm_checker u_checker (
        .clk(clk), .rst(rst), .write(write), .addr(addr), .din(din), .exp_strb(exp_strb),
        .clk_en(clk_en), .busy(busy), .timer(timer), .lfo(lfo), .pcm(pcm), .test(test),
        .upd(upd), .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic add_row(input logic [3:0] id, input logic part, input logic [7:0] num,
                           input logic rnd, input logic [7:0] data, input logic [10:0] strb);
        rows.push_back({id, part, num, rnd, data, strb});
    endtask

    task automatic build_table();
        add_row(2, 0, fm_pkg::REG_TIMA_HI,  1, 8'h00, 11'h000);
        add_row(2, 0, fm_pkg::REG_TIMA_LO,  1, 8'h00, 11'h000);
        add_row(2, 0, fm_pkg::REG_TIMB,     1, 8'h00, 11'h000);
        add_row(2, 0, fm_pkg::REG_TIMER,    0, 8'h3F, 11'h000);
        add_row(2, 0, fm_pkg::REG_TIMER,    0, 8'h15, 11'h000);
        add_row(3, 0, fm_pkg::REG_LFO,      0, 8'h0D, 11'h000);
        add_row(3, 0, fm_pkg::REG_TEST,     0, 8'h2C, 11'h000);
        add_row(3, 1, fm_pkg::REG_LFO,      0, 8'h00, 11'h000);  // Part 1 is ignored
        add_row(3, 1, fm_pkg::REG_TEST,     0, 8'h00, 11'h000);
        add_row(4, 0, fm_pkg::REG_PCM,      1, 8'h00, 11'h000);
        add_row(4, 0, fm_pkg::REG_DAC_TEST, 0, 8'h00, 11'h000);
        add_row(4, 0, fm_pkg::REG_DAC_TEST, 0, 8'h08, 11'h000);
        add_row(4, 0, fm_pkg::REG_PCM_EN,   0, 8'h80, 11'h000);
        add_row(4, 0, fm_pkg::REG_PCM,      0, 8'h00, 11'h000);
        add_row(4, 0, fm_pkg::REG_PCM_EN,   0, 8'h00, 11'h000);
        // Operator groups 3..9 map to opreg bits 0..6
        add_row(5, 0, 8'h30, 1, 8'h00, {3'b000, 7'b0000001, 1'b0});
        add_row(5, 0, 8'h45, 1, 8'h00, {3'b000, 7'b0000010, 1'b0});
        add_row(5, 1, 8'h5A, 1, 8'h00, {3'b000, 7'b0000100, 1'b0});
        add_row(5, 0, 8'h6F, 1, 8'h00, {3'b000, 7'b0000000, 1'b0});  // Channel field 3
        add_row(5, 1, 8'h6E, 1, 8'h00, {3'b000, 7'b0001000, 1'b0});
        add_row(5, 1, 8'h7C, 1, 8'h00, {3'b000, 7'b0010000, 1'b0});
        add_row(5, 0, 8'h88, 1, 8'h00, {3'b000, 7'b0100000, 1'b0});
        add_row(5, 1, 8'h99, 1, 8'h00, {3'b000, 7'b1000000, 1'b0});
        add_row(5, 0, 8'hA1, 1, 8'h00, {3'b001, 7'b0000000, 1'b0});
        add_row(5, 1, 8'hB2, 1, 8'h00, {3'b010, 7'b0000000, 1'b0});
        add_row(5, 0, 8'hB4, 1, 8'h00, {3'b100, 7'b0000000, 1'b0});
        add_row(5, 0, 8'hA3, 1, 8'h00, {3'b000, 7'b0000000, 1'b0});
        add_row(5, 0, fm_pkg::REG_KEYON, 1, 8'h00, {3'b000, 7'b0000000, 1'b1});
        add_row(5, 1, fm_pkg::REG_KEYON, 1, 8'h00, {3'b000, 7'b0000000, 1'b0});
        add_row(6, 0, fm_pkg::REG_CLK_N2, 0, 8'h00, 11'h000);
        add_row(6, 0, fm_pkg::REG_TIMB,   0, 8'h5A, 11'h000);
        add_row(6, 0, fm_pkg::REG_CLK_N3, 0, 8'h00, 11'h000);
        add_row(6, 0, fm_pkg::REG_TIMB,   0, 8'hA5, 11'h000);
        add_row(6, 0, fm_pkg::REG_CLK_N6, 0, 8'h00, 11'h000);
        add_row(6, 0, fm_pkg::REG_TIMB,   1, 8'h00, 11'h000);
    endtask

    task automatic bus_write(input logic part, input logic phase, input logic [7:0] val);
        @(negedge clk);
        write = 1'b1;
        addr  = {part, phase};
        din   = val;
    endtask

    task automatic run_row(input row_t r);
        logic [7:0] val;
        val = r.rnd ? 8'($urandom()) : r.data;
        bus_write(r.part, 1'b0, r.num);
        exp_strb = r.strb;
        bus_write(r.part, 1'b1, val);
        @(negedge clk);
        write = 1'b0;
        while (!busy) @(negedge clk);       // Host polls busy before the next write
        while (busy) @(negedge clk);
        @(negedge clk);                     // Busy length is checked on the edge after the fall
    endtask

    task automatic wait_clk_en(input int n);
        repeat (n) begin
            @(negedge clk);
            while (!clk_en) @(negedge clk);
        end
    endtask

    task automatic report_test(input int id, input int err_start);
        $display("Test %0d %s (%0d errors)", id, (errors == err_start) ? "ok" : "failed",
                 errors - err_start);
    endtask

    initial begin
        int cur_id;
        int err_start;
        void'($urandom(5758));
        rst      = 1'b1;
        cen      = 1'b1;
        write    = 1'b0;
        addr     = 2'b00;
        din      = 8'h00;
        exp_strb = 11'h000;
        build_table();
        cycle_limit = (rows.size() + 1) * (fm_pkg::BUSY_TICKS * 6 + 16);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_clk_en(4);                     // Idle with the power-up divider
        @(negedge clk);
        report_test(1, 0);
        cur_id    = 2;
        err_start = errors;
        foreach (rows[i]) begin
            if (int'(rows[i].id) != cur_id) begin
                report_test(cur_id, err_start);
                cur_id    = int'(rows[i].id);
                err_start = errors;
            end
            run_row(rows[i]);
        end
        report_test(cur_id, err_start);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/fm_pkg.sv
verilog/fm_bus_latch.sv
verilog/fm_clk_div.sv
verilog/fm_busy.sv
verilog/fm_global_regs.sv
verilog/fm_update_decode.sv
verilog/fm_mmr.sv
dv/fm_checker.sv
dv/tb_fm_mmr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FM register front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fm_mmr -Mdir obj_dir -o sim_fm_mmr -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_fm_mmr)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
